//--- hdl/uart_link_pkg.sv
package uart_link_pkg;

  // command word: [15] write flag, [14:8] register address, [7:0] write data
  typedef logic [15:0] cmd_t;

  // payload of one serial frame
  typedef logic [7:0] byte_t;

  typedef logic [6:0] reg_addr_t;

  localparam int CMD_WRITE_BIT = 15;

  // start + 8 data + parity + stop
  localparam int FRAME_BITS = 11;

  // parity bit that makes data plus parity hold an odd number of ones
  function automatic logic odd_parity(input byte_t data);
    logic even_ones;
    even_ones = ~(^data);
    return even_ones;
  endfunction

endpackage

//--- hdl/uart_tx.sv
`timescale 1ns/100ps

module uart_tx
  import uart_link_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tx_start,
  input  byte_t tx_byte,
  output logic  tx,
  output logic  tx_busy
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(FRAME_BITS);

  logic [CNT_W-1:0]      clk_cnt;
  logic [IDX_W-1:0]      bit_idx;
  // bits still to send after the start bit, lsb goes out next
  logic [FRAME_BITS-2:0] shift_q;
  logic                  load;
  logic                  bit_end;
  logic                  busy_end;

  assign load    = tx_start && !tx_busy;
  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  // busy drops one cycle early so the next frame can follow the stop bit directly
  assign busy_end = (bit_idx == IDX_W'(FRAME_BITS - 1)) &&
                    (clk_cnt == CNT_W'(CLKS_PER_BIT - 2));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (load) begin
      // start bit goes out right away
      tx      <= 1'b0;
      tx_busy <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (tx_busy) begin
      if (bit_end) begin
        clk_cnt <= '0;
        bit_idx <= bit_idx + 1'b1;
        tx      <= shift_q[0];
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
      if (busy_end) begin
        tx_busy <= 1'b0;
      end
    end
  end

  // frame payload: stop, parity, data lsb first
  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= {1'b1, odd_parity(tx_byte), tx_byte};
    end else if (tx_busy && bit_end) begin
      shift_q <= {1'b1, shift_q[FRAME_BITS-2:1]};
    end
  end

endmodule

//--- hdl/uart_rx.sv
`timescale 1ns/100ps

module uart_rx
  import uart_link_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx,
  output logic  rx_vld,
  output byte_t rx_byte,
  output logic  rx_err
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int HALF  = CLKS_PER_BIT / 2;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             fall;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic             sample;
  logic             par_err;
  byte_t            shift_q;

  // two flops against metastability, one more for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev && !rx_sync;

  // start bit is checked at half a period, the rest one full period apart
  assign sample = (state == RX_START) ? (clk_cnt == CNT_W'(HALF - 1)) :
                                        (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= RX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      rx_vld  <= 1'b0;
    end else begin
      rx_vld <= 1'b0;
      if (state == RX_IDLE || sample) begin
        clk_cnt <= '0;
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
      case (state)
        RX_IDLE: begin
          if (fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (sample) begin
            // still high at mid-bit means a glitch
            state   <= rx_sync ? RX_IDLE : RX_DATA;
            bit_idx <= '0;
          end
        end
        RX_DATA: begin
          if (sample) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_PARITY;
            end
          end
        end
        RX_PARITY: begin
          if (sample) begin
            state <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (sample) begin
            state  <= RX_IDLE;
            rx_vld <= 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sample && state == RX_DATA) begin
      shift_q <= {rx_sync, shift_q[7:1]};
    end
    if (sample && state == RX_PARITY) begin
      par_err <= (rx_sync != odd_parity(shift_q));
    end
    if (sample && state == RX_STOP) begin
      rx_err <= par_err || !rx_sync;
    end
  end

  assign rx_byte = shift_q;

endmodule

//--- hdl/uart_cmd_ctrl.sv
`timescale 1ns/100ps

module uart_cmd_ctrl
  import uart_link_pkg::*;
#(
  parameter int CLKS_PER_BIT     = 434,
  parameter int RSP_TIMEOUT_BITS = 40
) (
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  output logic  cmd_rdy,
  output logic  tx_start,
  output byte_t tx_byte,
  input  logic  tx_busy,
  input  logic  rx_vld,
  input  byte_t rx_byte,
  input  logic  rx_err,
  output logic  read_vld,
  output byte_t read_data,
  output logic  read_err
);

  localparam int TMO_CYCLES = RSP_TIMEOUT_BITS * CLKS_PER_BIT;
  localparam int TMO_W      = $clog2(TMO_CYCLES);

  typedef enum logic [2:0] {
    IDLE,
    SEND_ADDR,
    WAIT_ADDR,
    SEND_DATA,
    WAIT_DATA,
    WAIT_RSP,
    DONE
  } state_t;

  state_t           state;
  cmd_t             cmd_q;
  reg_addr_t        addr;
  logic             is_write;
  logic [TMO_W-1:0] tmo_cnt;
  logic             tmo_done;

  assign is_write = cmd_q[CMD_WRITE_BIT];
  assign addr     = cmd_q[CMD_WRITE_BIT-1:8];
  assign tmo_done = (tmo_cnt == TMO_W'(TMO_CYCLES - 1));

  assign cmd_rdy  = (state == IDLE);
  assign tx_start = (state == SEND_ADDR) || (state == SEND_DATA);
  assign tx_byte  = (state == SEND_DATA) ? cmd_q[7:0] : {is_write, addr};
  assign read_vld = (state == DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      tmo_cnt <= '0;
    end else begin
      case (state)
        IDLE:      if (cmd_vld) state <= SEND_ADDR;
        SEND_ADDR: state <= WAIT_ADDR;
        WAIT_ADDR: begin
          if (!tx_busy) begin
            tmo_cnt <= '0;
            state   <= is_write ? SEND_DATA : WAIT_RSP;
          end
        end
        SEND_DATA: state <= WAIT_DATA;
        WAIT_DATA: if (!tx_busy) state <= IDLE;
        WAIT_RSP: begin
          // no reply in time ends the read as an error
          if (rx_vld || tmo_done) begin
            state <= DONE;
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        DONE:      state <= IDLE;
        default:   state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && cmd_vld) begin
      cmd_q <= cmd_in;
    end
    if (state == WAIT_RSP) begin
      if (rx_vld) begin
        read_data <= rx_byte;
        read_err  <= rx_err;
      end else if (tmo_done) begin
        read_data <= '0;
        read_err  <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/uart_cmd_master.sv
`timescale 1ns/100ps

module uart_cmd_master
  import uart_link_pkg::*;
#(
  parameter int CLKS_PER_BIT     = 434,
  parameter int RSP_TIMEOUT_BITS = 40
) (
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  output logic  cmd_rdy,
  output logic  read_vld,
  output byte_t read_data,
  output logic  read_err,
  output logic  tx,
  input  logic  rx
);

  logic  tx_start;
  byte_t tx_byte;
  logic  tx_busy;
  logic  rx_vld;
  byte_t rx_byte;
  logic  rx_err;

  uart_cmd_ctrl #(
    .CLKS_PER_BIT     (CLKS_PER_BIT),
    .RSP_TIMEOUT_BITS (RSP_TIMEOUT_BITS)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .rx_vld    (rx_vld),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_vld  (rx_vld),
    .rx_byte (rx_byte),
    .rx_err  (rx_err)
  );

endmodule

//--- sim/uart_dev_model.sv
`timescale 1ns/100ps

module uart_dev_model
  import uart_link_pkg::*;
#(
  parameter int    CLKS_PER_BIT = 8,
  parameter byte_t FILL_XOR     = 8'hA5
) (
  input  logic clk,
  input  logic rst_n,
  input  logic tx,
  output logic rx,
  input  logic corrupt_next,
  input  logic mute_next,
  output logic frame_bad,
  output int   frames_rx
);

  byte_t mem [128];

  task automatic flag_bad_frame(input string what);
    $display("device model: %s in a received frame", what);
    frame_bad = 1'b1;
  endtask

  // samples mid-bit, counted in clock cycles from the start edge
  task automatic receive_frame(output byte_t data);
    byte_t d;
    logic  par;
    logic  stop;
    do @(negedge tx); while (!rst_n);
    repeat (CLKS_PER_BIT / 2) @(posedge clk);
    if (tx !== 1'b0) flag_bad_frame("start bit not low at mid-bit");
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      d[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    par = tx;
    repeat (CLKS_PER_BIT) @(posedge clk);
    stop = tx;
    frames_rx++;
    if (par !== odd_parity(d)) flag_bad_frame("wrong parity bit");
    if (stop !== 1'b1) flag_bad_frame("stop bit not high");
    data = d;
  endtask

  // bits change 1 ns after the rising edge
  task automatic send_frame(input byte_t data, input logic flip);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, odd_parity(data) ^ flip, data, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++) begin
      @(posedge clk);
      #1;
      rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  initial begin
    byte_t hdr;
    byte_t wdata;
    rx = 1'b1;
    frame_bad = 1'b0;
    frames_rx = 0;
    for (int i = 0; i < 128; i++) begin
      mem[i] = byte_t'(i) ^ FILL_XOR;
    end
    forever begin
      receive_frame(hdr);
      if (hdr[7]) begin
        receive_frame(wdata);
        mem[hdr[6:0]] = wdata;
      end else if (!mute_next) begin
        repeat (2 * CLKS_PER_BIT) @(posedge clk);
        send_frame(mem[hdr[6:0]], corrupt_next);
      end
    end
  end

endmodule

//--- sim/tb_uart_cmd_master.sv
`timescale 1ns/100ps

module tb_uart_cmd_master
  import uart_link_pkg::*;
();

  localparam int    CPB          = 8;
  localparam int    TMO_BITS     = 40;
  localparam byte_t FILL_XOR     = 8'hA5;
  localparam int    WAIT_LIMIT   = 2000;
  localparam int    WRITE_CYCLES = 2 * FRAME_BITS * CPB;

  logic  clk = 1'b0;
  logic  rst_n = 1'b0;
  cmd_t  cmd_in = '0;
  logic  cmd_vld = 1'b0;
  logic  cmd_rdy;
  logic  read_vld;
  byte_t read_data;
  logic  read_err;
  logic  tx;
  logic  rx;
  logic  corrupt_next = 1'b0;
  logic  mute_next = 1'b0;
  logic  frame_bad;
  int    frames_rx;

  byte_t       shadow [128];
  logic [8:0]  exp_q [$];
  logic [31:0] rng = 32'd86;
  int          writes_sent = 0;
  int          reads_sent = 0;
  int          last_wait = 0;

  always #2 clk = ~clk;

  uart_cmd_master #(
    .CLKS_PER_BIT     (CPB),
    .RSP_TIMEOUT_BITS (TMO_BITS)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err),
    .tx        (tx),
    .rx        (rx)
  );

  uart_dev_model #(
    .CLKS_PER_BIT (CPB),
    .FILL_XOR     (FILL_XOR)
  ) u_dev (
    .clk          (clk),
    .rst_n        (rst_n),
    .tx           (tx),
    .rx           (rx),
    .corrupt_next (corrupt_next),
    .mute_next    (mute_next),
    .frame_bad    (frame_bad),
    .frames_rx    (frames_rx)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                          $time, what, actual, expected));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // packed as {err, data}
  // a muted reply times out with zero data and a flipped parity keeps the byte
  function automatic logic [8:0] expected_read(input reg_addr_t addr, input logic corrupt,
                                               input logic mute);
    if (mute) return {1'b1, 8'h00};
    return {corrupt, shadow[addr]};
  endfunction

  // called and returns 1 ns after a rising edge
  task automatic send_cmd(input cmd_t cmd);
    int cycles;
    cycles = 0;
    cmd_in = cmd;
    cmd_vld = 1'b1;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("command was not accepted within the time limit");
    end while (!cmd_rdy);
    last_wait = cycles;
    if (cmd[CMD_WRITE_BIT]) begin
      shadow[cmd[CMD_WRITE_BIT-1:8]] = cmd[7:0];
      writes_sent++;
    end else begin
      exp_q.push_back(expected_read(cmd[CMD_WRITE_BIT-1:8], corrupt_next, mute_next));
      reads_sent++;
    end
    #1;
    cmd_vld = 1'b0;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("master did not return to idle within the time limit");
    end while (!(cmd_rdy && exp_q.size() == 0));
    #1;
  endtask

  always @(negedge clk) begin
    logic [8:0] expv;
    if (rst_n && read_vld) begin
      if (exp_q.size() == 0) begin
        abort_run("read result arrived with no read outstanding");
      end else begin
        expv = exp_q.pop_front();
        check_equal(32'(read_err), 32'(expv[8]), "read_err");
        check_equal(32'(read_data), 32'(expv[7:0]), "read_data");
      end
    end
  end

  always @(posedge frame_bad) begin
    abort_run("device model received a malformed frame");
  end

  initial begin
    cmd_t cmd;
    for (int i = 0; i < 128; i++) begin
      shadow[i] = byte_t'(i) ^ FILL_XOR;
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_equal(32'(tx), 32'd1, "tx idle after reset");
    check_equal(32'(cmd_rdy), 32'd1, "cmd_rdy after reset");
    check_equal(32'(read_vld), 32'd0, "read_vld after reset");

    // write then read back
    send_cmd({1'b1, 7'h15, 8'h3C});
    send_cmd({1'b0, 7'h15, 8'h00});
    wait_idle();

    // read held at the port while a write runs
    send_cmd({1'b1, 7'h2A, 8'h81});
    send_cmd({1'b0, 7'h2A, 8'h00});
    check_equal(32'(last_wait >= WRITE_CYCLES), 32'd1, "held read accepted before write end");
    wait_idle();

    corrupt_next = 1'b1;
    send_cmd({1'b0, 7'h15, 8'h00});
    wait_idle();
    corrupt_next = 1'b0;
    send_cmd({1'b0, 7'h15, 8'h00});
    wait_idle();

    // no reply so the read times out
    mute_next = 1'b1;
    send_cmd({1'b0, 7'h2A, 8'h00});
    wait_idle();
    mute_next = 1'b0;
    send_cmd({1'b0, 7'h2A, 8'h00});
    wait_idle();

    // small address range so reads hit earlier writes
    for (int n = 0; n < 200; n++) begin
      rng = xorshift(rng);
      cmd = {rng[0], 2'b00, rng[20:16], rng[31:24]};
      send_cmd(cmd);
    end
    wait_idle();

    check_equal(32'(frames_rx), 32'(2 * writes_sent + reads_sent), "frames seen by the device");
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- compile.f
hdl/uart_link_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_cmd_ctrl.sv
hdl/uart_cmd_master.sv
sim/uart_dev_model.sv
sim/tb_uart_cmd_master.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass is decided from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module tb_uart_cmd_master -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: PASS" sim.log; then
  echo "run_sim: passed"
  exit 0
else
  echo "run_sim: pass message not found in sim.log"
  exit 1
fi
